// ==== m_cluster.f ====
hw/m_ext_pkg.sv
hw/m_dispatch.sv
hw/muldiv_lane.sv
hw/m_writeback.sv
hw/m_cluster.sv
verif/m_cluster_checker.sv
verif/m_cluster_tb.sv

// ==== Makefile ====
# Verilator build for the M-extension cluster

VERILATOR  ?= verilator
TOP        ?= m_cluster_tb
FILELIST   ?= m_cluster.f
BUILD_DIR  ?= obj_dir
LINT_FLAGS ?= --lint-only -Wall --timing
SIM_FLAGS  ?= --binary --timing -Wno-fatal
PASS_MSG   ?= ALL CHECKS PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

$(BUILD_DIR)/$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o $(TOP)

# status comes from the pass line in the output
sim: $(BUILD_DIR)/$(TOP)
	@out="$$(./$(BUILD_DIR)/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== verif/m_cluster_tb.sv ====
`default_nettype none

module m_cluster_tb
  import m_ext_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned XW    = 32;
  localparam int unsigned LANES = 4;
  // stimulus size and limits
  localparam int NUM_ISSUES   = 2000;
  localparam int BURST        = 40;
  localparam int MAX_CYCLES   = 20000;
  localparam int DRAIN_CYCLES = 50;

  logic          clk;
  logic          rst;
  logic          issue;
  logic [31:0]   insn;
  logic [XW-1:0] rs1;
  logic [XW-1:0] rs2;
  logic          res_valid;
  result_t       res;

  int value_errs;
  int seq_errs;
  int checked;
  int pending;
  int timeouts;
  int sent;
  int cycles;
  int wait_cycles;

  // 40 ns period
  always #20 clk = ~clk;

  m_cluster #(
    .XW    (XW),
    .LANES (LANES)
  ) dut_i (
    .clk       (clk),
    .rst       (rst),
    .issue     (issue),
    .insn      (insn),
    .rs1       (rs1),
    .rs2       (rs2),
    .res_valid (res_valid),
    .res       (res)
  );

  m_cluster_checker checker_i (
    .clk        (clk),
    .rst        (rst),
    .issue      (issue),
    .insn       (insn),
    .rs1        (rs1),
    .rs2        (rs2),
    .res_valid  (res_valid),
    .res        (res),
    .value_errs (value_errs),
    .seq_errs   (seq_errs),
    .checked    (checked),
    .pending    (pending)
  );

  // operands biased toward the corner cases
  function automatic logic [31:0] pick_operand();
    logic [31:0] v;
    case ($urandom % 8)
      0:       v = 32'h0000_0000;
      1:       v = 32'hffff_ffff;
      2:       v = 32'h8000_0000;
      3:       v = 32'h7fff_ffff;
      4:       v = 32'($urandom % 16);
      5:       v = -32'($urandom % 16);
      default: v = $urandom;
    endcase
    return v;
  endfunction

  // mostly M ops, some near misses on opcode or funct7
  function automatic logic [31:0] make_insn();
    logic [31:0] w;
    int unsigned kind;
    w        = $urandom;
    kind     = $urandom % 10;
    w[6:0]   = OPC_OP;
    w[31:25] = F7_MULDIV;
    case (kind)
      // plain OP, e.g. ADD
      0:       w[31:25] = 7'b0000000;
      // SUB/SRA funct7
      1:       w[31:25] = 7'b0100000;
      // OP-IMM opcode
      2:       w[6:0] = 7'b0010011;
      default: ;
    endcase
    return w;
  endfunction

  initial
  begin
    clk      = 1'b0;
    rst      = 1'b1;
    issue    = 1'b0;
    insn     = '0;
    rs1      = '0;
    rs2      = '0;
    timeouts = 0;
    sent     = 0;
    cycles   = 0;
    void'($urandom(32'hca80_7d17));
    repeat (10) @(posedge clk);
    rst <= 1'b0;
    // quiet gap, res_valid must stay low here
    repeat (5) @(posedge clk);
    // back-to-back burst first, then about 70 percent
    while (sent < NUM_ISSUES && cycles < MAX_CYCLES)
    begin
      @(posedge clk);
      cycles++;
      if (sent < BURST || ($urandom % 100) < 70)
      begin
        issue <= 1'b1;
        insn  <= make_insn();
        rs1   <= pick_operand();
        rs2   <= pick_operand();
        sent++;
      end
      else
      begin
        issue <= 1'b0;
      end
    end
    if (sent < NUM_ISSUES)
    begin
      $display("stimulus ran out of cycles after issuing %0d of %0d", sent, NUM_ISSUES);
      timeouts++;
    end
    @(posedge clk);
    issue <= 1'b0;
    // wait for outstanding results
    wait_cycles = 0;
    @(posedge clk);
    while (pending != 0 && wait_cycles < DRAIN_CYCLES)
    begin
      @(posedge clk);
      wait_cycles++;
    end
    if (pending != 0)
    begin
      $display("timed out waiting for %0d outstanding results", pending);
      timeouts++;
    end
    // a few idle cycles to catch stray results
    for (int i = 0; i < 4; i++)
    begin
      @(posedge clk);
    end
    $display("checked %0d of %0d: %0d value errors, %0d sequence errors, %0d timeouts",
             checked, sent, value_errs, seq_errs, timeouts);
    if (value_errs == 0 && seq_errs == 0 && timeouts == 0 && checked == NUM_ISSUES)
      $display("ALL CHECKS PASSED");
    else
      $display("CHECKS FAILED");
    $finish;
  end

endmodule : m_cluster_tb

`default_nettype wire

// ==== verif/m_cluster_checker.sv ====
`default_nettype none

module m_cluster_checker
  import m_ext_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  // issue side of the DUT
  input  logic        issue,
  input  logic [31:0] insn,
  input  logic [31:0] rs1,
  input  logic [31:0] rs2,
  // result side of the DUT
  input  logic        res_valid,
  input  result_t     res,
  // running counts for the closing line
  output int          value_errs,
  output int          seq_errs,
  output int          checked,
  output int          pending
);
  timeunit 1ns;
  timeprecision 1ps;

  // issue to result latency in cycles
  localparam int unsigned LATENCY = 3;

  // expected results with due cycle and source word in issue order
  result_t     exp_q [$];
  int unsigned due_q [$];
  logic [31:0] insn_q [$];

  int unsigned cycle = 0;
  int          n_value = 0;
  int          n_seq = 0;
  int          n_checked = 0;

  // signed quotient under RV32 rules
  function automatic logic [31:0] div_signed(input logic [31:0] a, input logic [31:0] b);
    int sa;
    int sb;
    sa = a;
    sb = b;
    if (b == 32'd0)
      return 32'hffff_ffff;
    if (a == 32'h8000_0000 && b == 32'hffff_ffff)
      return 32'h8000_0000;
    return sa / sb;
  endfunction

  // signed remainder taking the sign of the dividend
  function automatic logic [31:0] rem_signed(input logic [31:0] a, input logic [31:0] b);
    int sa;
    int sb;
    sa = a;
    sb = b;
    if (b == 32'd0)
      return a;
    if (a == 32'h8000_0000 && b == 32'hffff_ffff)
      return 32'd0;
    return sa % sb;
  endfunction

  // reference model for one instruction word
  function automatic result_t model_result(input logic [31:0] w, input logic [31:0] a,
                                           input logic [31:0] b);
    result_t r;
    int      sa;
    int      sb;
    longint  xa;
    longint  xb;
    longint  za;
    longint  zb;
    longint  p_ss;
    longint  p_su;
    longint  p_uu;
    r.rd_idx  = w[11:7];
    r.value   = '0;
    r.illegal = 1'b0;
    // OP opcode with funct7 0000001 only
    if (w[6:0] != 7'b0110011 || w[31:25] != 7'b0000001)
    begin
      r.illegal = 1'b1;
      return r;
    end
    sa = a;
    sb = b;
    // sign and zero extended copies for the 64-bit products
    xa = sa;
    xb = sb;
    za = a;
    zb = b;
    p_ss = xa * xb;
    p_su = xa * zb;
    p_uu = za * zb;
    case (w[14:12])
      3'd0:    r.value = p_ss[31:0];
      3'd1:    r.value = p_ss[63:32];
      3'd2:    r.value = p_su[63:32];
      3'd3:    r.value = p_uu[63:32];
      3'd4:    r.value = div_signed(a, b);
      3'd5:    r.value = (b == 32'd0) ? 32'hffff_ffff : a / b;
      3'd6:    r.value = rem_signed(a, b);
      default: r.value = (b == 32'd0) ? a : a % b;
    endcase
    return r;
  endfunction

  always @(posedge clk)
  begin
    result_t     exp_res;
    int unsigned due;
    logic [31:0] word;
    cycle++;
    if (!rst)
    begin
      if (res_valid)
      begin
        if (exp_q.size() == 0)
        begin
          $display("extra result at %0d ns: rd %0d value %h with no instruction outstanding",
                   $time, res.rd_idx, res.value);
          n_seq++;
        end
        else
        begin
          exp_res = exp_q.pop_front();
          due     = due_q.pop_front();
          word    = insn_q.pop_front();
          // arrival cycle against issue cycle plus latency
          if (due != cycle)
          begin
            $display("result for insn %h arrived at cycle %0d instead of cycle %0d",
                     word, cycle, due);
            n_seq++;
          end
          if (res !== exp_res)
          begin
            $write("FAILED at %0d ns: insn %h expected rd %0d value %h illegal %0b",
                   $time, word, exp_res.rd_idx, exp_res.value, exp_res.illegal);
            $display(", got rd %0d value %h illegal %0b",
                     res.rd_idx, res.value, res.illegal);
            n_value++;
          end
          n_checked++;
        end
      end
      else if (due_q.size() > 0 && due_q[0] <= cycle)
      begin
        // head is overdue and nothing came back
        $display("missing result at %0d ns for insn %h, expected at cycle %0d",
                 $time, insn_q[0], due_q[0]);
        exp_res = exp_q.pop_front();
        due     = due_q.pop_front();
        word    = insn_q.pop_front();
        n_seq++;
      end
      // new instruction enters the model
      if (issue)
      begin
        exp_q.push_back(model_result(insn, rs1, rs2));
        due_q.push_back(cycle + LATENCY);
        insn_q.push_back(insn);
      end
    end
    value_errs <= n_value;
    seq_errs   <= n_seq;
    checked    <= n_checked;
    pending    <= exp_q.size();
  end

endmodule : m_cluster_checker

`default_nettype wire

// ==== hw/m_cluster.sv ====
`default_nettype none

module m_cluster
  import m_ext_pkg::*;
#(
  // must match XW_DEFAULT for the struct fields
  parameter int unsigned XW    = 32,
  parameter int unsigned LANES = 4
)(
  input  logic          clk,
  input  logic          rst,
  // instruction issue, one per cycle at most
  input  logic          issue,
  input  logic [31:0]   insn,
  input  logic [XW-1:0] rs1,
  input  logic [XW-1:0] rs2,
  // results, 3 cycles after issue
  output logic          res_valid,
  output result_t       res
);

  // dispatch to lanes
  logic [LANES-1:0] lane_valid;
  issue_t           lane_in;
  // illegal bypass
  logic             bypass_valid;
  logic [4:0]       bypass_rd;
  // lanes to writeback
  logic [LANES-1:0] lane_out_valid;
  result_t          lane_out [LANES];

  // decode and round-robin
  m_dispatch #(
    .XW    (XW),
    .LANES (LANES)
  ) dispatch_i (
    .clk          (clk),
    .rst          (rst),
    .issue        (issue),
    .insn         (insn),
    .rs1          (rs1),
    .rs2          (rs2),
    .lane_valid   (lane_valid),
    .lane_in      (lane_in),
    .bypass_valid (bypass_valid),
    .bypass_rd    (bypass_rd)
  );

  // identical lanes, shared payload bus
  for (genvar g = 0; g < LANES; g++)
  begin : gen_lane
    muldiv_lane #(
      .XW (XW)
    ) lane_i (
      .clk       (clk),
      .rst       (rst),
      .in_valid  (lane_valid[g]),
      .in        (lane_in),
      .out_valid (lane_out_valid[g]),
      .out       (lane_out[g])
    );
  end

  // merge into one ordered stream
  m_writeback #(
    .LANES (LANES)
  ) writeback_i (
    .clk          (clk),
    .rst          (rst),
    .lane_valid   (lane_out_valid),
    .lane_out     (lane_out),
    .bypass_valid (bypass_valid),
    .bypass_rd    (bypass_rd),
    .res_valid    (res_valid),
    .res          (res)
  );

endmodule : m_cluster

`default_nettype wire

// ==== hw/m_writeback.sv ====
`default_nettype none

module m_writeback
  import m_ext_pkg::*;
#(
  parameter int unsigned LANES = 4
)(
  input  logic             clk,
  input  logic             rst,
  // finishing lanes, at most one high
  input  logic [LANES-1:0] lane_valid,
  input  result_t          lane_out [LANES],
  // illegal path from dispatch
  input  logic             bypass_valid,
  input  logic [4:0]       bypass_rd,
  // in-order result stream
  output logic             res_valid,
  output result_t          res
);

  logic    byp_valid_q;
  logic [4:0] byp_rd_q;
  result_t sel;
  logic    sel_valid;

  // bypass delay, matches the lane register
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      byp_valid_q <= 1'b0;
    end
    else
    begin
      byp_valid_q <= bypass_valid;
    end
  end

  always_ff @(posedge clk)
  begin
    if (bypass_valid)
    begin
      byp_rd_q <= bypass_rd;
    end
  end

  // pick the one active source
  always_comb
  begin
    sel = '0;
    for (int i = 0; i < LANES; i++)
    begin
      if (lane_valid[i])
      begin
        sel = lane_out[i];
      end
    end
    // illegal answer, zero value
    if (byp_valid_q)
    begin
      sel = '{rd_idx: byp_rd_q, value: '0, illegal: 1'b1};
    end
  end

  assign sel_valid = |lane_valid || byp_valid_q;

  // output strobe
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      res_valid <= 1'b0;
    end
    else
    begin
      res_valid <= sel_valid;
    end
  end

  // output payload
  always_ff @(posedge clk)
  begin
    if (sel_valid)
    begin
      res <= sel;
    end
  end

endmodule : m_writeback

`default_nettype wire

// ==== hw/muldiv_lane.sv ====
`default_nettype none

module muldiv_lane
  import m_ext_pkg::*;
#(
  parameter int unsigned XW = 32
)(
  input  logic    clk,
  input  logic    rst,
  // work strobe and instruction
  input  logic    in_valid,
  input  issue_t  in,
  // answer, one cycle later
  output logic    out_valid,
  output result_t out
);

  // most negative value
  localparam logic [XW-1:0] M8 = {1'b1, {(XW - 1){1'b0}}};
  // minus one
  localparam logic [XW-1:0] M1 = '1;

  logic [XW-1:0]        a;
  logic [XW-1:0]        b;
  logic [2*XW-1:0]      ax;
  logic [2*XW-1:0]      bx;
  logic [2*XW-1:0]      mul;
  logic [XW-1:0]        divu;
  logic signed [XW-1:0] divs;
  logic [XW-1:0]        remu;
  logic signed [XW-1:0] rems;
  logic                 dz;
  logic                 ovf;
  logic [XW-1:0]        div;
  logic [XW-1:0]        rem;
  logic [XW-1:0]        value;

  // operands from the shared payload
  assign a = in.rs1;
  assign b = in.rs2;

  // corner cases
  // divide by zero
  assign dz  = ~|b;
  // signed overflow, most negative over -1
  assign ovf = (a == M8) && (b == M1);

  // operands widened to the product width
  // s12[1] sign-extends rs1, s12[0] sign-extends rs2
  always_comb
  begin
    ax = in.ctl.s12[1] ? {{XW{a[XW-1]}}, a} : {{XW{1'b0}}, a};
    bx = in.ctl.s12[0] ? {{XW{b[XW-1]}}, b} : {{XW{1'b0}}, b};
  end

  // low 2*XW bits of the product are right for every mix of signs
  assign mul = ax * bx;

  // raw quotient and remainder
  // signed results land in signed variables so the operators stay signed
  always_comb
  begin
    divu = a / b;
    divs = $signed(a) / $signed(b);
    remu = a % b;
    rems = $signed(a) % $signed(b);
  end

  // quotient with the spec rules
  // zero divisor gives all ones, overflow gives the dividend
  always_comb
  begin
    if (dz)
    begin
      div = '1;
    end
    else if (in.ctl.s12[1])
    begin
      div = ovf ? M8 : divs;
    end
    else
    begin
      div = divu;
    end
  end

  // remainder with the spec rules
  // zero divisor returns the dividend, overflow returns zero
  always_comb
  begin
    if (dz)
    begin
      rem = a;
    end
    else if (in.ctl.s12[1])
    begin
      rem = ovf ? '0 : rems;
    end
    else
    begin
      rem = remu;
    end
  end

  // result select by operation class
  always_comb
  begin
    case (in.ctl.op)
      M_MUL:   value = mul[XW-1:0];
      M_MUH:   value = mul[2*XW-1:XW];
      M_DIV:   value = div;
      default: value = rem;
    endcase
  end

  // output strobe
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      out_valid <= 1'b0;
    end
    else
    begin
      out_valid <= in_valid;
    end
  end

  // output payload
  always_ff @(posedge clk)
  begin
    if (in_valid)
    begin
      out.rd_idx  <= in.rd_idx;
      out.value   <= value;
      // lanes only ever see legal work
      out.illegal <= 1'b0;
    end
  end

endmodule : muldiv_lane

`default_nettype wire

// ==== hw/m_dispatch.sv ====
`default_nettype none

module m_dispatch
  import m_ext_pkg::*;
#(
  parameter int unsigned XW    = 32,
  parameter int unsigned LANES = 4
)(
  input  logic             clk,
  input  logic             rst,
  // incoming instruction strobe
  input  logic             issue,
  input  logic [31:0]      insn,
  input  logic [XW-1:0]    rs1,
  input  logic [XW-1:0]    rs2,
  // one-hot lane strobe, shared payload
  output logic [LANES-1:0] lane_valid,
  output issue_t           lane_in,
  // illegal instruction path
  output logic             bypass_valid,
  output logic [4:0]       bypass_rd
);

  // pointer width, at least one bit even for a single lane
  localparam int unsigned PW = (LANES > 1) ? $clog2(LANES) : 1;

  logic [6:0]    opcode;
  logic [4:0]    rd;
  logic [2:0]    funct3;
  logic [6:0]    funct7;
  logic          legal;
  ctl_m_t        ctl;
  logic [PW-1:0] ptr;

  // R-type field extraction
  assign opcode = insn[6:0];
  assign rd     = insn[11:7];
  assign funct3 = insn[14:12];
  assign funct7 = insn[31:25];

  // OP major opcode with the MULDIV funct7
  assign legal = (opcode == OPC_OP) && (funct7 == F7_MULDIV);

  // funct3 to operation and signedness
  always_comb
  begin
    case (funct3)
      3'b000:  ctl = '{op: M_MUL, s12: S12_SS};
      3'b001:  ctl = '{op: M_MUH, s12: S12_SS};
      3'b010:  ctl = '{op: M_MUH, s12: S12_SU};
      3'b011:  ctl = '{op: M_MUH, s12: S12_UU};
      3'b100:  ctl = '{op: M_DIV, s12: S12_SS};
      3'b101:  ctl = '{op: M_DIV, s12: S12_UU};
      3'b110:  ctl = '{op: M_REM, s12: S12_SS};
      default: ctl = '{op: M_REM, s12: S12_UU};
    endcase
  end

  // strobes and round-robin pointer
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      lane_valid   <= '0;
      bypass_valid <= 1'b0;
      ptr          <= '0;
    end
    else
    begin
      // exactly one lane gets a legal instruction
      lane_valid   <= (issue && legal) ? (LANES'(1) << ptr) : '0;
      bypass_valid <= issue && !legal;
      // pointer moves only on legal work
      if (issue && legal)
      begin
        ptr <= (ptr == PW'(LANES - 1)) ? '0 : ptr + 1'b1;
      end
    end
  end

  // payload, loaded only on a legal issue
  always_ff @(posedge clk)
  begin
    if (issue && legal)
    begin
      lane_in <= '{rd_idx: rd, rs1: rs1, rs2: rs2, ctl: ctl};
    end
    // rd travels with the illegal pulse
    if (issue && !legal)
    begin
      bypass_rd <= rd;
    end
  end

endmodule : m_dispatch

`default_nettype wire

// ==== hw/m_ext_pkg.sv ====
`default_nettype none

package m_ext_pkg;

  // datapath width that sizes the shared structs
  parameter int unsigned XW_DEFAULT = 32;

  // major opcode OP, R-type integer ops
  localparam logic [6:0] OPC_OP = 7'b0110011;
  // funct7 marking the M extension
  localparam logic [6:0] F7_MULDIV = 7'b0000001;

  // operand signedness, rs1 in bit 1, rs2 in bit 0
  localparam logic [1:0] S12_UU = 2'b00;
  localparam logic [1:0] S12_SU = 2'b10;
  localparam logic [1:0] S12_SS = 2'b11;

  // operation class
  typedef enum logic [1:0] {
    // low half of the product
    M_MUL = 2'b00,
    // high half of the product
    M_MUH = 2'b01,
    // quotient
    M_DIV = 2'b10,
    // remainder
    M_REM = 2'b11
  } m_op_t;

  // lane control, 4 bits
  typedef struct packed {
    m_op_t      op;
    // signedness of rs1/rs2
    logic [1:0] s12;
  } ctl_m_t;

  // one dispatched instruction
  typedef struct packed {
    // destination register index
    logic [4:0]            rd_idx;
    // source operands
    logic [XW_DEFAULT-1:0] rs1;
    logic [XW_DEFAULT-1:0] rs2;
    // decoded operation
    ctl_m_t                ctl;
  } issue_t;

  // one returned answer
  typedef struct packed {
    logic [4:0]            rd_idx;
    // zero when illegal is set
    logic [XW_DEFAULT-1:0] value;
    // not an M-extension instruction
    logic                  illegal;
  } result_t;

endpackage : m_ext_pkg

`default_nettype wire
